//--- Makefile
# Verilator build and run of the divide unit testbench
# override any variable on the command line, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= divUnitTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timing -Wno-fatal

.PHONY: sim clean

# a $fatal in the testbench gives a nonzero exit status and fails the target
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- design/divIssue.sv
// ====================================================================
// divide issue stage
// holds one request, launches the divider and queues finished results
// ====================================================================

`timescale 1ns/1ps
`include "divUnit_cfg.svh"

module divIssue #(
	parameter int DEPTH = `DIV_FIFO_DEPTH
) (
	input  logic                   clk,
	input  logic                   rst,
	input  divPkg::divReq          req,
	input  logic                   reqStrobe,
	input  logic                   abort,
	input  logic                   done,
	input  logic                   idle,
	input  logic [$clog2(DEPTH):0] count,
	output logic                   full,
	output logic                   ld,
	output logic                   sgn,
	output logic                   sgnus,
	output divPkg::divWord         a,
	output divPkg::divWord         b,
	output logic                   divAbort,
	output divPkg::divEntry        wrEntry,
	output logic                   wrStrobe,
	input  divPkg::divWord         qo,
	input  divPkg::divWord         ro,
	input  logic                   dvByZr
);

	// the request waiting for the divider
	divPkg::divReq holdReq;

	// tag and opcode of the division currently running
	logic          inFlight;
	divPkg::divTag flightTag;
	divPkg::divOp  flightOp;

	// ================================================================
	// launch
	// ================================================================

	// a free FIFO slot is reserved here, so the completion write never overflows
	assign ld = full && !inFlight && idle && (int'(count) < DEPTH) && !abort;

	// operands go straight from the holding register
	assign a = holdReq.a;
	assign b = holdReq.b;

	// both operands are signed for the plain signed opcodes
	assign sgn = (holdReq.op == divPkg::opDiv) || (holdReq.op == divPkg::opRem);
	// only the dividend is signed in the mixed mode
	assign sgnus = (holdReq.op == divPkg::opDivsu) || (holdReq.op == divPkg::opRemsu);

	// the divider only needs to hear about an abort when it is working for us
	assign divAbort = abort && inFlight;

	// holding register, loaded by the strobe and emptied by a launch
	always_ff @(posedge clk) begin
		if (rst) begin
			full <= 1'b0;
		end else if (abort) begin
			full <= 1'b0;
		end else if (reqStrobe) begin
			full <= 1'b1;
		end else if (ld) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reqStrobe) begin
			holdReq <= req;
		end
	end

	// ================================================================
	// completion
	// ================================================================

	// one division at a time, cleared by its done cycle or by an abort
	always_ff @(posedge clk) begin
		if (rst) begin
			inFlight <= 1'b0;
		end else if (abort) begin
			inFlight <= 1'b0;
		end else if (ld) begin
			inFlight <= 1'b1;
		end else if (done && inFlight) begin
			inFlight <= 1'b0;
		end
	end

	// keep tag and opcode since the holding register may refill meanwhile
	always_ff @(posedge clk) begin
		if (ld) begin
			flightTag <= holdReq.tag;
			flightOp  <= holdReq.op;
		end
	end

	// the divider outputs are valid for the whole done cycle
	assign wrStrobe = done && inFlight && !abort;

	always_comb begin
		wrEntry.tag       = flightTag;
		wrEntry.op        = flightOp;
		wrEntry.quotient  = qo;
		wrEntry.remainder = ro;
		wrEntry.divByZero = dvByZr;
	end

endmodule

//--- design/divPkg.sv
// ====================================================================
// divide unit types
// shared vector, enum and struct types of the divide unit
// ====================================================================

`include "divUnit_cfg.svh"

package divPkg;

	// an operand, a quotient or a remainder
	typedef logic [`DIV_WIDTH-1:0] divWord;

	// request identifier, handed back with the result
	typedef logic [`DIV_TAG_WIDTH-1:0] divTag;

	// the three quotient opcodes come first, then the three remainder opcodes
	typedef enum logic [2:0] {
		opDiv   = 3'd0,
		opDivu  = 3'd1,
		opDivsu = 3'd2,
		opRem   = 3'd3,
		opRemu  = 3'd4,
		opRemsu = 3'd5
	} divOp;

	// states of the sequential divider
	typedef enum logic [1:0] {
		stIdle = 2'd0,
		stDiv  = 2'd1,
		stDone = 2'd2
	} divState;

	// one divide request as it arrives from the pipeline
	typedef struct packed {
		divTag  tag;
		divOp   op;
		divWord a;
		divWord b;
	} divReq;

	// a finished division waiting in the result FIFO
	typedef struct packed {
		divTag  tag;
		divOp   op;
		divWord quotient;
		divWord remainder;
		logic   divByZero;
	} divEntry;

	// the value handed back to the pipeline
	typedef struct packed {
		divTag  tag;
		divWord value;
		logic   divByZero;
	} divResult;

endpackage

//--- design/divResultFifo.sv
// ====================================================================
// divide result FIFO
// circular buffer of finished divisions with an occupancy count
// ====================================================================

`timescale 1ns/1ps
`include "divUnit_cfg.svh"

module divResultFifo #(
	parameter int DEPTH = `DIV_FIFO_DEPTH
) (
	input  logic                   clk,
	input  logic                   rst,
	input  divPkg::divEntry        wrEntry,
	input  logic                   wrStrobe,
	input  logic                   rdStrobe,
	output divPkg::divEntry        rdEntry,
	output logic                   empty,
	output logic [$clog2(DEPTH):0] count
);

	// pointers need at least one bit even for a single entry
	localparam int ptrWidth = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam logic [ptrWidth-1:0] lastIdx = ptrWidth'(DEPTH - 1);

	divPkg::divEntry     mem [DEPTH];
	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;

	// head entry is visible as soon as it is written
	assign rdEntry = mem[rdPtr];
	assign empty   = count == '0;

	// the users never write a full FIFO nor read an empty one
	always_ff @(posedge clk) begin
		if (wrStrobe) begin
			mem[wrPtr] <= wrEntry;
		end
	end

	// pointers wrap at DEPTH, so any depth works
	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
		end else begin
			if (wrStrobe) begin
				wrPtr <= (wrPtr == lastIdx) ? '0 : wrPtr + 1'b1;
			end
			if (rdStrobe) begin
				rdPtr <= (rdPtr == lastIdx) ? '0 : rdPtr + 1'b1;
			end
		end
	end

	// occupancy stays put when a write and a read meet
	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else begin
			case ({wrStrobe, rdStrobe})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- design/divUnit.sv
// ====================================================================
// sequential divide unit
// issue stage, divider, result FIFO and writeback stage
// ====================================================================

`timescale 1ns/1ps
`include "divUnit_cfg.svh"

module divUnit (
	input  logic             clk,
	input  logic             rst,
	input  divPkg::divReq    req,
	input  logic             reqStrobe,
	input  logic             abort,
	input  logic             stall,
	output logic             full,
	output divPkg::divResult result,
	output logic             resultStrobe
);

	// issue stage to divider
	logic           ld;
	logic           sgn;
	logic           sgnus;
	logic           divAbort;
	divPkg::divWord a;
	divPkg::divWord b;
	divPkg::divWord qo;
	divPkg::divWord ro;
	logic           dvByZr;
	logic           done;
	logic           idle;

	// issue stage and writeback around the FIFO
	divPkg::divEntry                  wrEntry;
	logic                             wrStrobe;
	divPkg::divEntry                  rdEntry;
	logic                             rdStrobe;
	logic                             empty;
	logic [$clog2(`DIV_FIFO_DEPTH):0] count;

	divIssue #(.DEPTH(`DIV_FIFO_DEPTH)) u_divIssue (
		.clk(clk), .rst(rst), .req(req), .reqStrobe(reqStrobe), .abort(abort),
		.done(done), .idle(idle), .count(count), .full(full), .ld(ld),
		.sgn(sgn), .sgnus(sgnus), .a(a), .b(b), .divAbort(divAbort),
		.wrEntry(wrEntry), .wrStrobe(wrStrobe), .qo(qo), .ro(ro), .dvByZr(dvByZr)
	);

	divider #(.WID(`DIV_WIDTH)) u_divider (
		.rst(rst), .clk(clk), .ld(ld), .abort(divAbort), .sgn(sgn), .sgnus(sgnus),
		.a(a), .b(b), .qo(qo), .ro(ro), .dvByZr(dvByZr), .done(done), .idle(idle)
	);

	divResultFifo #(.DEPTH(`DIV_FIFO_DEPTH)) u_divResultFifo (
		.clk(clk), .rst(rst), .wrEntry(wrEntry), .wrStrobe(wrStrobe),
		.rdStrobe(rdStrobe), .rdEntry(rdEntry), .empty(empty), .count(count)
	);

	divWriteback u_divWriteback (
		.clk(clk), .rst(rst), .rdEntry(rdEntry), .empty(empty), .stall(stall),
		.rdStrobe(rdStrobe), .result(result), .resultStrobe(resultStrobe)
	);

endmodule

//--- design/divUnit_cfg.svh
// ====================================================================
// divide unit configuration
// sizes shared by the package and the RTL of the divide unit
// ====================================================================

`ifndef DIV_UNIT_CFG_SVH
`define DIV_UNIT_CFG_SVH

// operand and result width in bits
`define DIV_WIDTH 32

// width of the tag that travels with each request
`define DIV_TAG_WIDTH 4

// number of finished entries the result FIFO can hold
`define DIV_FIFO_DEPTH 4

`endif

//--- design/divWriteback.sv
// ====================================================================
// divide writeback stage
// pops finished entries and returns the quotient or the remainder
// ====================================================================

`timescale 1ns/1ps

module divWriteback (
	input  logic             clk,
	input  logic             rst,
	input  divPkg::divEntry  rdEntry,
	input  logic             empty,
	input  logic             stall,
	output logic             rdStrobe,
	output divPkg::divResult result,
	output logic             resultStrobe
);

	divPkg::divWord selValue;

	// stall keeps entries in the FIFO
	assign rdStrobe = !empty && !stall;

	// quotient opcodes return the quotient, the rest return the remainder
	always_comb begin
		case (rdEntry.op)
			divPkg::opDiv,
			divPkg::opDivu,
			divPkg::opDivsu: selValue = rdEntry.quotient;
			default:         selValue = rdEntry.remainder;
		endcase
	end

	// result holds its value until the next pop
	always_ff @(posedge clk) begin
		if (rdStrobe) begin
			result.tag       <= rdEntry.tag;
			result.value     <= selValue;
			result.divByZero <= rdEntry.divByZero;
		end
	end

	// one strobe cycle per popped entry
	always_ff @(posedge clk) begin
		if (rst) begin
			resultStrobe <= 1'b0;
		end else begin
			resultStrobe <= rdStrobe;
		end
	end

endmodule

//--- design/divider.sv
// ====================================================================
// radix-2 restoring divider
// signed, mixed and unsigned division with divide-by-zero and abort
// ====================================================================

`timescale 1ns/1ps
`include "divUnit_cfg.svh"

module divider #(
	// the bit counter is 8 bits, so widths up to 254 work
	parameter int WID = `DIV_WIDTH
) (
	input  logic           rst,
	input  logic           clk,
	input  logic           ld,
	input  logic           abort,
	input  logic           sgn,
	input  logic           sgnus,
	input  logic [WID-1:0] a,
	input  logic [WID-1:0] b,
	output logic [WID-1:0] qo,
	output logic [WID-1:0] ro,
	output logic           dvByZr,
	output logic           done,
	output logic           idle
);

	divPkg::divState state;
	logic [7:0]      cnt;

	// divisor magnitude, quotient shift register and partial remainder
	logic [WID-1:0] bb;
	logic [WID-1:0] q;
	// r carries the partial remainder shifted up one, with the next dividend bit below it
	logic [WID:0]   r;
	// sign of the result
	logic           so;

	logic           b0;
	logic [WID:0]   diff;
	logic [WID-1:0] r1;
	logic [WID-1:0] qNext;
	logic           lastStep;
	logic [WID-1:0] aMag;
	logic [WID-1:0] bMag;

	// fixed outputs for a zero divisor
	localparam logic [WID-1:0] zeroDivPos = {1'b0, {(WID-1){1'b1}}};
	localparam logic [WID-1:0] zeroDivNeg = {1'b1, {(WID-1){1'b0}}};

	// done marks only the cycle where qo and ro are final
	assign done = state == divPkg::stDone;
	assign idle = state == divPkg::stIdle;

	// the last of the WID+1 shift cycles
	assign lastStep = cnt == 8'd1;

	// restoring step: subtract the divisor when it fits
	assign diff  = r - {1'b0, bb};
	assign b0    = {1'b0, bb} <= r;
	// the difference is always below the divisor, so WID bits hold it
	assign r1    = b0 ? diff[WID-1:0] : r[WID-1:0];
	assign qNext = {q[WID-2:0], b0};

	assign aMag = a[WID-1] ? -a : a;
	assign bMag = b[WID-1] ? -b : b;

	// ================================================================
	// control
	// ================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= divPkg::stIdle;
			cnt    <= 8'd0;
			dvByZr <= 1'b0;
		end else if (abort) begin
			// drop the division and wait for the next load
			state <= divPkg::stIdle;
			cnt   <= 8'd0;
		end else begin
			case (state)
				divPkg::stIdle: begin
					if (ld) begin
						state  <= divPkg::stDiv;
						cnt    <= 8'(WID + 1);
						dvByZr <= b == '0;
					end
				end
				divPkg::stDiv: begin
					// a zero divisor skips the shifting entirely
					if (dvByZr || lastStep) begin
						state <= divPkg::stDone;
					end
					if (!dvByZr) begin
						cnt <= cnt - 8'd1;
					end
				end
				divPkg::stDone: begin
					state <= divPkg::stIdle;
				end
				default: begin
					state <= divPkg::stIdle;
				end
			endcase
		end
	end

	// ================================================================
	// datapath
	// ================================================================

	always_ff @(posedge clk) begin
		case (state)
			divPkg::stIdle: begin
				if (ld) begin
					r <= '0;
					if (sgn) begin
						q  <= aMag;
						bb <= bMag;
						so <= a[WID-1] ^ b[WID-1];
					end else if (sgnus) begin
						// mixed mode takes the divisor as it is
						q  <= aMag;
						bb <= b;
						so <= a[WID-1];
					end else begin
						q  <= a;
						bb <= b;
						so <= 1'b0;
					end
				end
			end
			divPkg::stDiv: begin
				if (dvByZr) begin
					qo <= so ? zeroDivNeg : zeroDivPos;
					ro <= so ? zeroDivNeg : zeroDivPos;
				end else begin
					// first step shifts in a dummy zero that falls out at the end
					q <= qNext;
					r <= {r1, q[WID-1]};
					// remainder takes the same sign as the quotient
					if (lastStep) begin
						qo <= so ? -qNext : qNext;
						ro <= so ? -r1 : r1;
					end
				end
			end
			default: begin
			end
		endcase
	end

endmodule

//--- filelist.f
+incdir+design
design/divPkg.sv
design/divIssue.sv
design/divider.sv
design/divResultFifo.sv
design/divWriteback.sv
design/divUnit.sv
verification/clockGen.sv
verification/divUnitTb.sv

//--- verification/clockGen.sv
// ====================================================================
// testbench clock and reset
// ====================================================================

`timescale 1ns/1ps

module clockGen #(
	parameter int periodNs    = 100,
	parameter int resetCycles = 5
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(periodNs / 2) clk = ~clk;
	end

	// reset drops right after the last reset edge has been sampled
	initial begin
		rst = 1'b1;
		repeat (resetCycles) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

//--- verification/divUnitTb.sv
// ====================================================================
// divide unit testbench
// directed tests against a reference model of the divide rules
// ====================================================================

`timescale 1ns/1ps
`include "divUnit_cfg.svh"

module divUnitTb;

	localparam int driveDelayNs  = 10;
	localparam int timeoutCycles = 4 * `DIV_WIDTH + 20;
	localparam divPkg::divWord minWord = {1'b1, {(`DIV_WIDTH-1){1'b0}}};
	localparam divPkg::divWord maxWord = {1'b0, {(`DIV_WIDTH-1){1'b1}}};

	logic             clk;
	logic             rst;
	divPkg::divReq    req;
	logic             reqStrobe;
	logic             abort;
	logic             stall;
	logic             full;
	divPkg::divResult result;
	logic             resultStrobe;

	logic [15:0]      lfsrState;
	divPkg::divTag    nextTag;
	// expected results in request order
	divPkg::divResult expQ[$];

	clockGen #(.periodNs(100), .resetCycles(5)) u_clockGen (.clk(clk), .rst(rst));

	divUnit u_divUnit (
		.clk(clk), .rst(rst), .req(req), .reqStrobe(reqStrobe), .abort(abort),
		.stall(stall), .full(full), .result(result), .resultStrobe(resultStrobe)
	);

	// ================================================================
	// helpers
	// ================================================================

	task automatic reportFailure(string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic checkEqual(string name, logic [63:0] got, logic [63:0] exp);
		assert (got == exp) else begin
			reportFailure($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
		end
	endtask

	// inputs change and outputs are sampled a little after each rising edge
	task automatic nextCycle();
		@(posedge clk);
		#(driveDelayNs);
	endtask

	// taps 16 14 13 11 give a maximal length sequence
	function automatic logic [15:0] lfsrNext(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// the register steps once for every bit handed out
	function automatic divPkg::divWord randBits(int n);
		divPkg::divWord w;
		w = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			w = {w[`DIV_WIDTH-2:0], lfsrState[0]};
		end
		return w;
	endfunction

	// expected value straight from the sign and divide-by-zero rules
	function automatic divPkg::divWord refValue(divPkg::divOp op, divPkg::divWord a,
			divPkg::divWord b);
		logic           aSigned;
		logic           bSigned;
		logic           neg;
		divPkg::divWord aAbs;
		divPkg::divWord bAbs;
		divPkg::divWord q;
		divPkg::divWord r;
		aSigned = (op == divPkg::opDiv) || (op == divPkg::opRem) ||
			(op == divPkg::opDivsu) || (op == divPkg::opRemsu);
		// the mixed mode leaves the divisor unsigned
		bSigned = (op == divPkg::opDiv) || (op == divPkg::opRem);
		aAbs = (aSigned && a[`DIV_WIDTH-1]) ? -a : a;
		bAbs = (bSigned && b[`DIV_WIDTH-1]) ? -b : b;
		neg  = (aSigned && a[`DIV_WIDTH-1]) ^ (bSigned && b[`DIV_WIDTH-1]);
		if (b == '0) begin
			q = neg ? minWord : maxWord;
			r = q;
		end else begin
			q = aAbs / bAbs;
			r = aAbs % bAbs;
			// remainder follows the quotient sign
			if (neg) begin
				q = -q;
				r = -r;
			end
		end
		if ((op == divPkg::opRem) || (op == divPkg::opRemu) || (op == divPkg::opRemsu)) begin
			return r;
		end
		return q;
	endfunction

	task automatic sendRequest(divPkg::divOp op, divPkg::divWord a, divPkg::divWord b);
		int               cycles;
		divPkg::divResult exp;
		cycles = 0;
		while (full) begin
			assert (cycles < timeoutCycles) else reportFailure("timed out waiting for full to drop");
			nextCycle();
			cycles++;
		end
		req.tag       = nextTag;
		req.op        = op;
		req.a         = a;
		req.b         = b;
		reqStrobe     = 1'b1;
		exp.tag       = nextTag;
		exp.value     = refValue(op, a, b);
		exp.divByZero = b == '0;
		expQ.push_back(exp);
		nextTag = nextTag + divPkg::divTag'(1);
		nextCycle();
		reqStrobe = 1'b0;
	endtask

	// catches the next strobe and compares it with the oldest expected result
	task automatic waitResult();
		int               cycles;
		divPkg::divResult exp;
		nextCycle();
		cycles = 1;
		while (!resultStrobe) begin
			assert (cycles < timeoutCycles) else reportFailure("timed out waiting for resultStrobe");
			nextCycle();
			cycles++;
		end
		exp = expQ.pop_front();
		checkEqual("result.tag", 64'(result.tag), 64'(exp.tag));
		checkEqual("result.value", 64'(result.value), 64'(exp.value));
		checkEqual("result.divByZero", 64'(result.divByZero), 64'(exp.divByZero));
	endtask

	task automatic runDivision(divPkg::divOp op, divPkg::divWord a, divPkg::divWord b);
		sendRequest(op, a, b);
		waitResult();
	endtask

	// ================================================================
	// directed tests
	// ================================================================

	task automatic checkResetState();
		repeat (8) begin
			nextCycle();
			checkEqual("full", 64'(full), 64'(0));
			checkEqual("resultStrobe", 64'(resultStrobe), 64'(0));
		end
	endtask

	task automatic unsignedOps();
		divPkg::divWord a;
		divPkg::divWord b;
		// divisors above the dividend first
		runDivision(divPkg::opDivu, divPkg::divWord'(5), divPkg::divWord'(32'h1000));
		runDivision(divPkg::opRemu, divPkg::divWord'(32'h1234), -divPkg::divWord'(16));
		repeat (40) begin
			a = randBits(`DIV_WIDTH);
			// shorter divisors give quotients of every size
			b = randBits(`DIV_WIDTH) >> randBits(5);
			if (b == '0) begin
				b = divPkg::divWord'(1);
			end
			runDivision(divPkg::opDivu, a, b);
			runDivision(divPkg::opRemu, a, b);
		end
	endtask

	task automatic signedSet(divPkg::divWord a, divPkg::divWord b);
		runDivision(divPkg::opDiv, a, b);
		runDivision(divPkg::opRem, a, b);
		runDivision(divPkg::opDivsu, a, b);
		runDivision(divPkg::opRemsu, a, b);
	endtask

	task automatic signedOps();
		divPkg::divWord a;
		divPkg::divWord b;
		signedSet(divPkg::divWord'(7), divPkg::divWord'(2));
		signedSet(-divPkg::divWord'(7), divPkg::divWord'(2));
		signedSet(divPkg::divWord'(7), -divPkg::divWord'(2));
		signedSet(-divPkg::divWord'(7), -divPkg::divWord'(2));
		signedSet(minWord, -divPkg::divWord'(1));
		signedSet(minWord, divPkg::divWord'(1));
		signedSet(maxWord, minWord);
		signedSet(-divPkg::divWord'(1), divPkg::divWord'(3));
		signedSet('0, -divPkg::divWord'(5));
		repeat (12) begin
			a = randBits(`DIV_WIDTH);
			b = randBits(`DIV_WIDTH) >> randBits(5);
			if (randBits(1) != '0) begin
				b = -b;
			end
			if (b == '0) begin
				b = divPkg::divWord'(1);
			end
			signedSet(a, b);
		end
	endtask

	task automatic divideByZeroCases();
		divPkg::divOp op;
		for (int i = 0; i < 6; i++) begin
			op = divPkg::divOp'(3'(i));
			runDivision(op, divPkg::divWord'(5), '0);
			runDivision(op, -divPkg::divWord'(5), '0);
		end
	endtask

	task automatic backPressureOrder();
		stall = 1'b1;
		// DEPTH entries fill the FIFO and one more stays in the holding register
		repeat (`DIV_FIFO_DEPTH + 1) begin
			sendRequest(divPkg::opDivu, randBits(`DIV_WIDTH), randBits(16) | divPkg::divWord'(1));
		end
		repeat (3 * `DIV_WIDTH) begin
			nextCycle();
			assert (full) else reportFailure("full dropped while the FIFO was full");
			assert (!resultStrobe) else reportFailure("a result came back while stalled");
		end
		stall = 1'b0;
		repeat (`DIV_FIFO_DEPTH + 1) begin
			waitResult();
		end
	endtask

	task automatic abortInFlight();
		sendRequest(divPkg::opDivu, randBits(`DIV_WIDTH), divPkg::divWord'(3));
		// the division is a few steps in by now
		repeat (6) begin
			nextCycle();
		end
		abort = 1'b1;
		nextCycle();
		abort = 1'b0;
		repeat (3 * `DIV_WIDTH) begin
			nextCycle();
			assert (!resultStrobe) else reportFailure("a result came back for an aborted division");
		end
		expQ.delete();
		runDivision(divPkg::opRem, -divPkg::divWord'(100), divPkg::divWord'(7));
	endtask

	// ================================================================
	// test sequence
	// ================================================================

	initial begin
		int cycles;
		req       = '0;
		reqStrobe = 1'b0;
		abort     = 1'b0;
		stall     = 1'b0;
		lfsrState = 16'd1242;
		nextTag   = '0;
		nextCycle();
		cycles = 0;
		while (rst) begin
			assert (cycles < timeoutCycles) else reportFailure("reset never went low");
			nextCycle();
			cycles++;
		end
		checkResetState();
		unsignedOps();
		signedOps();
		divideByZeroCases();
		backPressureOrder();
		abortInFlight();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule
